/* logic/src_addr_gen.sv */
// 2-D address walker; pattern and bias sampled at start, d0_len of 0 is not supported
`timescale 1ns/1ps
`default_nettype none

module src_addr_gen (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire logic          clear_i,
  input  wire logic          start_i,
  input  wire src_pkg::addr_t base_addr_i,
  input  wire src_pkg::addr_t bias_i,
  input  wire logic          use_bias_i,
  input  wire src_pkg::cnt_t  tot_len_i,
  input  wire src_pkg::cnt_t  d0_len_i,
  input  wire src_pkg::addr_t d0_stride_i,
  input  wire src_pkg::addr_t d1_stride_i,
  output logic               addr_valid_o,
  output src_pkg::addr_t     addr_o,
  input  wire logic          addr_ready_i,
  output logic               done_o
);

  import src_pkg::*;

  addr_t row_q;       // start of current row
  addr_t cur_q;       // address on offer
  addr_t d0_stride_q;
  addr_t d1_stride_q;
  cnt_t  tot_q;
  cnt_t  d0_len_q;
  cnt_t  inner_q;     // position inside the row
  cnt_t  sent_q;      // addresses accepted so far
  logic  active_q;
  logic  done_q;
  addr_t start_addr;
  logic  accept;

  assign start_addr   = base_addr_i + (use_bias_i ? bias_i : '0); // bias applies once
  assign accept       = active_q & addr_ready_i; // FIFO takes the address
  assign addr_valid_o = active_q;
  assign addr_o       = cur_q;
  assign done_o       = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_q       <= '0;
      cur_q       <= '0;
      d0_stride_q <= '0;
      d1_stride_q <= '0;
      tot_q       <= '0;
      d0_len_q    <= '0;
      inner_q     <= '0;
      sent_q      <= '0;
      active_q    <= 1'b0;
      done_q      <= 1'b0;
    end else if (clear_i) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
    end else if (start_i) begin // presample pattern
      row_q       <= start_addr;
      cur_q       <= start_addr;
      d0_stride_q <= d0_stride_i;
      d1_stride_q <= d1_stride_i;
      tot_q       <= tot_len_i;
      d0_len_q    <= d0_len_i;
      inner_q     <= '0;
      sent_q      <= '0;
      active_q    <= (tot_len_i != '0);
      done_q      <= (tot_len_i == '0); // empty pattern finishes at once
    end else if (accept) begin
      sent_q <= sent_q + 1'b1;
      if (sent_q + cnt_t'(1) == tot_q) begin // last address taken
        active_q <= 1'b0;
        done_q   <= 1'b1;
      end else if (inner_q + cnt_t'(1) == d0_len_q) begin // end of row
        row_q   <= row_q + d1_stride_q;
        cur_q   <= row_q + d1_stride_q;
        inner_q <= '0;
      end else begin
        cur_q   <= cur_q + d0_stride_q;
        inner_q <= inner_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/src_biased_source.sv */
// top level; memory must answer in order and keep at most SRC_OFS_FIFO_DEPTH loads outstanding
`timescale 1ns/1ps
`default_nettype none

`include "src_consts.svh"

module src_biased_source (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               clear_i,
  input  wire logic               req_start_i,
  input  wire src_pkg::addr_t     base_addr_i,
  input  wire src_pkg::cnt_t      tot_len_i,
  input  wire src_pkg::cnt_t      d0_len_i,
  input  wire src_pkg::addr_t     d0_stride_i,
  input  wire src_pkg::addr_t     d1_stride_i,
  input  wire logic               bias_valid_i,
  input  wire src_pkg::addr_t     bias_data_i,
  output logic                    bias_ready_o,
  input  wire logic               ignore_bias_i,
  output logic                    ready_start_o,
  output logic                    done_o,
  output logic                    mem_req_o,
  output src_pkg::addr_t          mem_addr_o,
  input  wire logic               mem_gnt_i,
  output logic                    mem_rready_o,
  input  wire logic               mem_rvalid_i,
  input  wire src_pkg::mem_data_t mem_rdata_i,
  output logic                    stream_valid_o,
  output src_pkg::stream_data_t   stream_data_o,
  input  wire logic               stream_ready_i
);

  import src_pkg::*;

  logic  start;
  logic  active;
  logic  gen_done;
  logic  gen_valid;
  addr_t gen_addr;
  logic  gen_ready;
  logic  fifo_valid;
  addr_t fifo_addr;
  logic  fifo_empty;
  logic  issue;  // load granted
  logic  xfer;   // item left on the stream

  assign mem_req_o    = active & fifo_valid & stream_ready_i; // no loads under back-pressure
  assign mem_addr_o   = {fifo_addr[`SRC_ADDR_W-1:2], 2'b00}; // word aligned
  assign mem_rready_o = stream_ready_i;
  assign issue        = mem_req_o & mem_gnt_i;
  assign xfer         = stream_valid_o & stream_ready_i;

  src_addr_gen src_addr_gen_inst (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .start_i      ( start          ),
    .base_addr_i  ( base_addr_i    ),
    .bias_i       ( bias_data_i    ),
    .use_bias_i   ( ~ignore_bias_i ),
    .tot_len_i    ( tot_len_i      ),
    .d0_len_i     ( d0_len_i       ),
    .d0_stride_i  ( d0_stride_i    ),
    .d1_stride_i  ( d1_stride_i    ),
    .addr_valid_o ( gen_valid      ),
    .addr_o       ( gen_addr       ),
    .addr_ready_i ( gen_ready      ),
    .done_o       ( gen_done       )
  );

  src_fifo #(
    .DEPTH     ( `SRC_ADDR_FIFO_DEPTH ),
    .payload_t ( addr_t               )
  ) addr_fifo_inst (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .push_valid_i ( gen_valid  ),
    .push_data_i  ( gen_addr   ),
    .push_ready_o ( gen_ready  ),
    .pop_valid_o  ( fifo_valid ),
    .pop_data_o   ( fifo_addr  ),
    .pop_ready_i  ( issue      ), // pop on grant
    .empty_o      ( fifo_empty )
  );

  src_realign src_realign_inst (
    .clk_i          ( clk_i           ),
    .rst_ni         ( rst_ni          ),
    .clear_i        ( clear_i         ),
    .issue_i        ( issue           ),
    .issue_ofs_i    ( fifo_addr[1:0]  ), // low bits travel with the load
    .mem_rvalid_i   ( mem_rvalid_i    ),
    .mem_rdata_i    ( mem_rdata_i     ),
    .stream_valid_o ( stream_valid_o  ),
    .stream_data_o  ( stream_data_o   ),
    .stream_ready_i ( stream_ready_i  )
  );

  src_ctrl src_ctrl_inst (
    .clk_i             ( clk_i         ),
    .rst_ni            ( rst_ni        ),
    .clear_i           ( clear_i       ),
    .req_start_i       ( req_start_i   ),
    .bias_valid_i      ( bias_valid_i  ),
    .ignore_bias_i     ( ignore_bias_i ),
    .tot_len_i         ( tot_len_i     ),
    .gen_done_i        ( gen_done      ),
    .addr_fifo_empty_i ( fifo_empty    ),
    .xfer_i            ( xfer          ),
    .start_o           ( start         ),
    .active_o          ( active        ),
    .ready_start_o     ( ready_start_o ),
    .done_o            ( done_o        ),
    .bias_ready_o      ( bias_ready_o  )
  );

endmodule

`default_nettype wire

/* logic/src_consts.svh */
// widths and depths; the memory word must be exactly 32 bits wider than the stream
`ifndef SRC_CONSTS_SVH
`define SRC_CONSTS_SVH

// byte address width
`define SRC_ADDR_W 32

// output stream item width
`define SRC_STREAM_W 32

// memory data width, one extra word for misaligned reads
`define SRC_MEM_W (`SRC_STREAM_W + 32)

// length fields and delivered-item counter
`define SRC_CNT_W 16

// address FIFO between walker and memory port
`define SRC_ADDR_FIFO_DEPTH 2

// offset FIFO, also the cap on granted but unanswered loads
`define SRC_OFS_FIFO_DEPTH 8

`endif

/* logic/src_ctrl.sv */
// idle/working/done control; tot_len is latched at start, a run ends only after all items leave
`timescale 1ns/1ps
`default_nettype none

module src_ctrl (
  input  wire logic         clk_i,
  input  wire logic         rst_ni,
  input  wire logic         clear_i,
  input  wire logic         req_start_i,
  input  wire logic         bias_valid_i,
  input  wire logic         ignore_bias_i,
  input  wire src_pkg::cnt_t tot_len_i,
  input  wire logic         gen_done_i,
  input  wire logic         addr_fifo_empty_i,
  input  wire logic         xfer_i,
  output logic              start_o,
  output logic              active_o,
  output logic              ready_start_o,
  output logic              done_o,
  output logic              bias_ready_o
);

  import src_pkg::*;

  src_state_e state_q;
  src_state_e state_d;
  cnt_t       cnt_q;   // delivered items
  cnt_t       tot_q;   // items expected this run

  assign ready_start_o = (state_q == SRC_IDLE);
  assign active_o      = (state_q != SRC_IDLE);
  assign start_o       = ready_start_o & req_start_i & (ignore_bias_i | bias_valid_i);
  assign bias_ready_o  = start_o & ~ignore_bias_i; // bias consumed with the start
  assign done_o        = (state_q == SRC_DONE) & addr_fifo_empty_i & (cnt_q == tot_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      SRC_IDLE:    if (start_o) state_d = SRC_WORKING;
      SRC_WORKING: if (gen_done_i) state_d = SRC_DONE; // all addresses queued
      SRC_DONE:    if (done_o) state_d = SRC_IDLE;     // last item delivered
      default:     state_d = SRC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SRC_IDLE;
      cnt_q   <= '0;
      tot_q   <= '0;
    end else if (clear_i) begin
      state_q <= SRC_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (start_o) tot_q <= tot_len_i;
      if (done_o) cnt_q <= '0; // ready for next run
      else if (xfer_i) cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/src_fifo.sv */
// flop-based FIFO, no fall-through; pushing into a full FIFO is dropped, DEPTH >= 1
`timescale 1ns/1ps
`default_nettype none

module src_fifo #(
  parameter int unsigned DEPTH = 2,
  parameter type payload_t = logic [31:0]
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     clear_i,
  input  wire logic     push_valid_i,
  input  wire payload_t push_data_i,
  output logic          push_ready_o,
  output logic          pop_valid_o,
  output payload_t      pop_data_o,
  input  wire logic     pop_ready_i,
  output logic          empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH]; // storage, no reset
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;         // occupancy
  logic             push;
  logic             pop;

  assign push_ready_o = (cnt_q != CNT_W'(DEPTH)); // not full
  assign pop_valid_o  = (cnt_q != '0);
  assign empty_o      = (cnt_q == '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin // drop all entries
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1; // wrap
      if (pop) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop) cnt_q <= cnt_q + 1'b1;
      else if (pop && !push) cnt_q <= cnt_q - 1'b1; // push and pop together keep count
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data_i;
  end

endmodule

`default_nettype wire

/* logic/src_pkg.sv */
// shared types; widths come from src_consts.svh and must not be changed here
`default_nettype none

package src_pkg;

  `include "src_consts.svh"

  // byte address
  typedef logic [`SRC_ADDR_W-1:0] addr_t;

  // lengths and item counts
  typedef logic [`SRC_CNT_W-1:0] cnt_t;

  // byte offset inside a 32-bit word
  typedef logic [1:0] ofs_t;

  // one output item
  typedef logic [`SRC_STREAM_W-1:0] stream_data_t;

  // one memory response
  typedef logic [`SRC_MEM_W-1:0] mem_data_t;

  // controller states
  typedef enum logic [1:0] {
    SRC_IDLE    = 2'd0,
    SRC_WORKING = 2'd1,
    SRC_DONE    = 2'd2
  } src_state_e;

endpackage

`default_nettype wire

/* logic/src_realign.sv */
// offset FIFO, hold register and byte realign; responses arriving with no offset are dropped
`timescale 1ns/1ps
`default_nettype none

`include "src_consts.svh"

module src_realign (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               clear_i,
  input  wire logic               issue_i,
  input  wire src_pkg::ofs_t      issue_ofs_i,
  input  wire logic               mem_rvalid_i,
  input  wire src_pkg::mem_data_t mem_rdata_i,
  output logic                    stream_valid_o,
  output src_pkg::stream_data_t   stream_data_o,
  input  wire logic               stream_ready_i
);

  import src_pkg::*;

  ofs_t      ofs;         // offset of the oldest unanswered load
  logic      ofs_valid;
  logic      hold_valid_q;
  mem_data_t hold_data_q; // payload, no reset
  mem_data_t sel_data;
  mem_data_t shifted;
  logic      hold_load;
  logic      xfer;

  src_fifo #(
    .DEPTH     ( `SRC_OFS_FIFO_DEPTH ),
    .payload_t ( ofs_t               )
  ) ofs_fifo_inst (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .clear_i      ( clear_i     ),
    .push_valid_i ( issue_i     ), // memory limits outstanding loads
    .push_data_i  ( issue_ofs_i ),
    .push_ready_o (             ),
    .pop_valid_o  ( ofs_valid   ),
    .pop_data_o   ( ofs         ),
    .pop_ready_i  ( xfer        ), // one offset per item
    .empty_o      (             )
  );

  // held item is older than a live one
  assign sel_data       = hold_valid_q ? hold_data_q : mem_rdata_i;
  assign stream_valid_o = ofs_valid & (hold_valid_q | mem_rvalid_i);
  assign xfer           = stream_valid_o & stream_ready_i;

  assign shifted       = sel_data >> {ofs, 3'b000}; // drop ofs leading bytes
  assign stream_data_o = shifted[`SRC_STREAM_W-1:0];

  // capture a live response that cannot leave this cycle
  assign hold_load = mem_rvalid_i &
                     (hold_valid_q ? stream_ready_i : (ofs_valid & ~stream_ready_i));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else if (hold_load) begin
      hold_valid_q <= 1'b1;
    end else if (stream_ready_i) begin // held item left
      hold_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (hold_load) hold_data_q <= mem_rdata_i;
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; a failing run exits non-zero
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert \
  -f sim.f \
  --top-module tb_src_biased_source
./obj_dir/Vtb_src_biased_source

/* sim.f */
+incdir+logic
logic/src_pkg.sv
logic/src_fifo.sv
logic/src_addr_gen.sv
logic/src_realign.sv
logic/src_ctrl.sv
logic/src_biased_source.sv
sim/tb_src_biased_source.sv

/* sim/tb_src_biased_source.sv */
// self-checking testbench; memory answers in order, at most SRC_OFS_FIFO_DEPTH loads in flight
`timescale 1ns/1ps
`default_nettype none

`include "src_consts.svh"

module tb_src_biased_source;

  import src_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int NUM_RUNS     = 6;
  localparam int WATCHDOG_CYC = 16 + NUM_RUNS * 2000; // reset plus 2000 cycles per run

  logic         clk_i = 1'b0;
  logic         rst_ni;
  logic         clear_i;
  logic         req_start_i;
  addr_t        base_addr_i;
  cnt_t         tot_len_i;
  cnt_t         d0_len_i;
  addr_t        d0_stride_i;
  addr_t        d1_stride_i;
  logic         bias_valid_i;
  addr_t        bias_data_i;
  logic         bias_ready_o;
  logic         ignore_bias_i;
  logic         ready_start_o;
  logic         done_o;
  logic         mem_req_o;
  addr_t        mem_addr_o;
  logic         mem_gnt_i;
  logic         mem_rready_o;
  logic         mem_rvalid_i;
  mem_data_t    mem_rdata_i;
  logic         stream_valid_o;
  stream_data_t stream_data_o;
  logic         stream_ready_i;

  int          seed = 67007;
  int unsigned cycle_cnt = 0;
  int unsigned fail_cnt = 0;
  logic        rand_ready = 1'b0; // random back-pressure on the stream
  logic        check_en = 1'b0;   // comparator armed
  addr_t       cfg_base;          // base with bias already added
  int unsigned cfg_tot;
  int unsigned cfg_d0_len;
  addr_t       cfg_d0_stride;
  addr_t       cfg_d1_stride;
  int unsigned exp_idx = 0;       // next item index expected
  int unsigned issue_idx = 0;     // next load index expected on the memory port
  int unsigned done_cnt = 0;
  int unsigned bias_cnt = 0;
  addr_t       pend_addr[$];      // granted loads in issue order
  int unsigned pend_due[$];       // earliest answer cycle

  src_biased_source src_biased_source_inst (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // memory byte a holds low 8 bits of a*7+3
  function automatic logic [7:0] mem_byte(input addr_t a);
    addr_t v;
    v = a * 32'd7 + 32'd3;
    return v[7:0];
  endfunction

  function automatic mem_data_t mem_word(input addr_t a); // a word aligned
    mem_data_t w;
    int        i;
    for (i = 0; i < 8; i++) begin
      w[8*i +: 8] = mem_byte(a + addr_t'(i)); // byte a in low lane
    end
    return w;
  endfunction

  function automatic addr_t item_addr(input int unsigned k);
    return cfg_base + addr_t'(k % cfg_d0_len) * cfg_d0_stride
                    + addr_t'(k / cfg_d0_len) * cfg_d1_stride;
  endfunction

  // reference item as bytes a..a+3 little-endian
  function automatic stream_data_t expected_item(input int unsigned k);
    addr_t        a;
    stream_data_t d;
    int           i;
    a = item_addr(k);
    for (i = 0; i < 4; i++) begin
      d[8*i +: 8] = mem_byte(a + addr_t'(i));
    end
    return d;
  endfunction

  task automatic abort_run(input string msg);
    fail_cnt++;
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp) else
      abort_run($sformatf("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                          $time, name, exp, act));
  endtask

  // back-pressure and memory responses driven after each rising edge
  always @(posedge clk_i) begin
    int rnd;
    #2;
    rnd            = $random(seed);
    stream_ready_i = rand_ready ? (rnd[1] | rnd[2]) : 1'b1; // ready 3 of 4 when random
    mem_gnt_i      = rnd[3] & (pend_addr.size() < `SRC_OFS_FIFO_DEPTH);
    mem_rvalid_i   = 1'b0;
    mem_rdata_i    = '0;
    if (stream_ready_i && pend_due.size() != 0) begin // never answer while rready low
      if (pend_due[0] <= cycle_cnt) begin
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = mem_word(pend_addr[0]);
      end
    end
  end

  // memory bookkeeping on the falling edge where handshakes are stable
  always @(negedge clk_i) begin
    int rnd;
    if (!stream_ready_i) begin // back-pressure stops requests and responses
      check_val("mem_req_o", 32'd0, 32'(mem_req_o));
      check_val("mem_rready_o", 32'd0, 32'(mem_rready_o));
    end
    if (mem_rvalid_i) check_val("mem_rready_o", 32'd1, 32'(mem_rready_o)); // response on offer
    if (mem_req_o && mem_gnt_i) begin
      rnd = $random(seed);
      if (check_en) begin
        check_val("mem_addr_o", item_addr(issue_idx) & ~32'd3, mem_addr_o); // word aligned
      end
      issue_idx++;
      pend_addr.push_back(mem_addr_o);
      pend_due.push_back(cycle_cnt + 32'd1 + 32'(rnd[1:0])); // 0 to 3 cycles late
    end
    if (mem_rvalid_i && mem_rready_o) begin
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end
    if (clear_i) begin // drop loads of the cleared run
      pend_addr.delete();
      pend_due.delete();
    end
    cycle_cnt++;
  end

  // comparator
  always @(negedge clk_i) begin
    if (check_en && stream_valid_o && stream_ready_i) begin
      assert (exp_idx < cfg_tot) else
        abort_run("stream delivered more items than the run length");
      check_val("stream_data_o", expected_item(exp_idx), stream_data_o);
      exp_idx++;
    end
    if (done_o) begin
      done_cnt++;
      check_val("items delivered at done_o", cfg_tot, exp_idx); // done after last item
    end
    if (bias_ready_o) bias_cnt++;
  end

  task automatic start_run(input addr_t base, input addr_t bias, input logic ignore,
                           input int unsigned tot, input int unsigned len,
                           input addr_t s0, input addr_t s1);
    do @(negedge clk_i); while (!ready_start_o);
    @(posedge clk_i);
    #2;
    cfg_base      = ignore ? base : base + bias;
    cfg_tot       = tot;
    cfg_d0_len    = len;
    cfg_d0_stride = s0;
    cfg_d1_stride = s1;
    exp_idx       = 0;
    issue_idx     = 0;
    done_cnt      = 0;
    bias_cnt      = 0;
    check_en      = 1'b1;
    req_start_i   = 1'b1; // accepted at the next edge from idle
    base_addr_i   = base;
    tot_len_i     = cnt_t'(tot);
    d0_len_i      = cnt_t'(len);
    d0_stride_i   = s0;
    d1_stride_i   = s1;
    bias_valid_i  = ~ignore;
    bias_data_i   = bias;
    ignore_bias_i = ignore;
    @(posedge clk_i);
    #2;
    req_start_i  = 1'b0;
    bias_valid_i = 1'b0;
  endtask

  task automatic finish_run(input logic bias_used);
    do @(negedge clk_i); while (!done_o);
    @(negedge clk_i);
    check_val("ready_start_o", 32'd1, 32'(ready_start_o)); // one cycle after done
    repeat (4) @(posedge clk_i);
    check_val("done_o pulse count", 32'd1, done_cnt);
    check_val("item count", cfg_tot, exp_idx);
    check_val("bias_ready_o pulse count", 32'(bias_used), bias_cnt);
    check_en = 1'b0;
  endtask

  task automatic clear_midway();
    while (exp_idx < 10) @(posedge clk_i);
    check_en = 1'b0; // items of the cleared run are not checked
    #2;
    clear_i = 1'b1;
    @(posedge clk_i);
    #2;
    clear_i = 1'b0;
    @(negedge clk_i);
    check_val("ready_start_o", 32'd1, 32'(ready_start_o));
    check_val("done_o pulse count", 32'd0, done_cnt);
  endtask

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    abort_run("watchdog expired, the DUT never finished the test sequence");
  end

  initial begin
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    req_start_i    = 1'b0;
    base_addr_i    = '0;
    tot_len_i      = '0;
    d0_len_i       = '0;
    d0_stride_i    = '0;
    d1_stride_i    = '0;
    bias_valid_i   = 1'b0;
    bias_data_i    = '0;
    ignore_bias_i  = 1'b1;
    mem_gnt_i      = 1'b0;
    mem_rvalid_i   = 1'b0;
    mem_rdata_i    = '0;
    stream_ready_i = 1'b1;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_val("ready_start_o", 32'd1, 32'(ready_start_o)); // flags out of reset
    check_val("done_o", 32'd0, 32'(done_o));
    check_val("mem_req_o", 32'd0, 32'(mem_req_o));
    check_val("stream_valid_o", 32'd0, 32'(stream_valid_o));
    check_val("bias_ready_o", 32'd0, 32'(bias_ready_o));
    start_run(32'h100, 32'h80, 1'b1, 32, 32, 32'd4, 32'd0); // aligned, bias word ignored
    finish_run(1'b0);
    start_run(32'h201, 32'h2, 1'b0, 16, 16, 32'd5, 32'd0); // offsets 3 0 1 2 repeat
    finish_run(1'b1);
    start_run(32'h300, 32'h0, 1'b1, 9, 3, 32'd8, 32'h40); // 2-D pattern
    finish_run(1'b0);
    rand_ready = 1'b1;
    start_run(32'h402, 32'h0, 1'b1, 48, 8, 32'd6, 32'h80); // random ready and latency
    finish_run(1'b0);
    rand_ready = 1'b0;
    start_run(32'h800, 32'h10, 1'b0, 40, 40, 32'd4, 32'd0); // cut short by clear
    clear_midway();
    start_run(32'h901, 32'h0, 1'b1, 12, 4, 32'd4, 32'h20);
    finish_run(1'b0);
    if (fail_cnt == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run("run ended with failed checks");
    end
  end

endmodule

`default_nettype wire
